// ==== verilog/lc4_pkg.sv ====
// LC4 widths, encodings and pipeline structs shared by all RTL blocks through scoped names
`default_nettype none

package lc4_pkg;

   // Datapath words and fields
   typedef logic [15:0] word_t;
   typedef logic [2:0]  reg_idx_t;
   typedef logic [2:0]  nzp_t;

   // Boot address, default for the top-level parameter
   localparam word_t RESET_PC = 16'h8200;

   // Top nibble of the instruction word
   typedef enum logic [3:0] {
      OP_NOP     = 4'b0000,   // every branch-group word lands here
      OP_ARITH   = 4'b0001,
      OP_LOGIC   = 4'b0101,
      OP_LDR     = 4'b0110,
      OP_STR     = 4'b0111,
      OP_CONST   = 4'b1001,
      OP_HICONST = 4'b1101
   } opcode_e;

   // Operation carried out in execute
   typedef enum logic [3:0] {
      ALU_ADD       = 4'd0,
      ALU_MUL       = 4'd1,
      ALU_SUB       = 4'd2,
      ALU_AND       = 4'd3,
      ALU_NOT       = 4'd4,
      ALU_OR        = 4'd5,
      ALU_XOR       = 4'd6,
      ALU_PASS_IMM9 = 4'd7,
      ALU_HICONST   = 4'd8,
      ALU_ADDR6     = 4'd9   // Rs plus imm6 for LDR/STR
   } alu_op_e;

   // Stall code shown on the trace port
   typedef enum logic [1:0] {
      STALL_NONE     = 2'd0,
      STALL_FLUSH    = 2'd2,   // pipeline still filling after reset
      STALL_LOAD_USE = 2'd3
   } stall_e;

   // Execute operand sources
   localparam logic [1:0] BYP_REG = 2'd0;
   localparam logic [1:0] BYP_MX  = 2'd1;
   localparam logic [1:0] BYP_WX  = 2'd2;

   // Decoded control, travels with the instruction
   typedef struct packed {
      reg_idx_t r1sel;
      logic     r1re;
      reg_idx_t r2sel;
      logic     r2re;
      reg_idx_t wsel;
      logic     regfile_we;
      logic     nzp_we;
      logic     is_load;
      logic     is_store;
      alu_op_e  alu_op;
   } ctrl_t;

   // One pipeline stage register
   typedef struct packed {
      word_t  pc;
      word_t  insn;
      stall_e stall;
      ctrl_t  ctrl;
   } stage_t;

   // Committed instruction as seen at writeback
   typedef struct packed {
      stall_e   stall;
      word_t    pc;
      word_t    insn;
      logic     regfile_we;
      reg_idx_t wsel;
      word_t    wdata;
      logic     nzp_we;
      nzp_t     nzp_bits;
      logic     dmem_we;
      word_t    dmem_addr;
      word_t    dmem_data;
   } trace_t;

endpackage

`default_nettype wire

// ==== verilog/lc4_decoder.sv ====
// Decode stage logic, maps an LC4 instruction word onto the control struct of the pipeline
`timescale 1ns/10ps
`default_nettype none

module lc4_decoder (
   input  wire  lc4_pkg::word_t i_insn,
   output lc4_pkg::ctrl_t       o_ctrl
);

   always_comb begin
      lc4_pkg::opcode_e op;
      lc4_pkg::ctrl_t   c;
      op = lc4_pkg::opcode_e'(i_insn[15:12]);
      // Anything not matched below stays a NOP with all enables low
      c       = '0;
      c.r1sel = i_insn[8:6];
      c.r2sel = i_insn[2:0];
      c.wsel  = i_insn[11:9];
      case (op)
         lc4_pkg::OP_ARITH: begin
            // Sub-op 011 is DIV, not carried here
            if (i_insn[5:3] != 3'b011) begin
               c.r1re       = 1'b1;
               c.r2re       = !i_insn[5];
               c.regfile_we = 1'b1;
               c.nzp_we     = 1'b1;
               case (i_insn[5:3])
                  3'b001:  c.alu_op = lc4_pkg::ALU_MUL;
                  3'b010:  c.alu_op = lc4_pkg::ALU_SUB;
                  default: c.alu_op = lc4_pkg::ALU_ADD;   // register or imm5 form
               endcase
            end
         end
         lc4_pkg::OP_LOGIC: begin
            c.r1re       = 1'b1;
            // NOT and the imm5 AND take a single register
            c.r2re       = !i_insn[5] && (i_insn[4:3] != 2'b01);
            c.regfile_we = 1'b1;
            c.nzp_we     = 1'b1;
            case (i_insn[5:3])
               3'b001:  c.alu_op = lc4_pkg::ALU_NOT;
               3'b010:  c.alu_op = lc4_pkg::ALU_OR;
               3'b011:  c.alu_op = lc4_pkg::ALU_XOR;
               default: c.alu_op = lc4_pkg::ALU_AND;
            endcase
         end
         lc4_pkg::OP_LDR: begin
            c.r1re       = 1'b1;
            c.regfile_we = 1'b1;
            c.nzp_we     = 1'b1;
            c.is_load    = 1'b1;
            c.alu_op     = lc4_pkg::ALU_ADDR6;
         end
         lc4_pkg::OP_STR: begin
            // Store data register sits in the Rd field
            c.r1re     = 1'b1;
            c.r2sel    = i_insn[11:9];
            c.r2re     = 1'b1;
            c.is_store = 1'b1;
            c.alu_op   = lc4_pkg::ALU_ADDR6;
         end
         lc4_pkg::OP_CONST: begin
            c.regfile_we = 1'b1;
            c.nzp_we     = 1'b1;
            c.alu_op     = lc4_pkg::ALU_PASS_IMM9;
         end
         lc4_pkg::OP_HICONST: begin
            // Bit 8 set marks HICONST, and it keeps the low byte of its own Rd
            if (i_insn[8]) begin
               c.r1sel      = i_insn[11:9];
               c.r1re       = 1'b1;
               c.regfile_we = 1'b1;
               c.nzp_we     = 1'b1;
               c.alu_op     = lc4_pkg::ALU_HICONST;
            end
         end
         default: c = c;
      endcase
      o_ctrl = c;
   end

   // Memory access kinds are exclusive over the whole decode table
   always_comb begin
      assert (!(o_ctrl.is_load && o_ctrl.is_store))
         else $error("decoder flags insn %h as load and store", i_insn);
   end

endmodule

`default_nettype wire

// ==== verilog/lc4_regfile.sv ====
// Eight-entry LC4 register file, two reads in decode and one write from writeback
`timescale 1ns/10ps
`default_nettype none

module lc4_regfile (
   input  wire                    gwe,
   input  wire                    i_rst_n,
   input  wire  lc4_pkg::reg_idx_t i_rs,
   input  wire  lc4_pkg::reg_idx_t i_rt,
   input  wire  lc4_pkg::reg_idx_t i_rd,
   input  wire  lc4_pkg::word_t   i_wdata,
   input  wire                    i_rd_we,
   output lc4_pkg::word_t         o_rs_data,
   output lc4_pkg::word_t         o_rt_data
);

   lc4_pkg::word_t regs [8];

   // Registers start at zero
   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (i_rd_we) begin
         regs[i_rd] <= i_wdata;
      end
   end

   // Write-through, the value being written is seen by decode this cycle
   always_comb begin
      o_rs_data = regs[i_rs];
      o_rt_data = regs[i_rt];
      if (i_rd_we && i_rd == i_rs) begin
         o_rs_data = i_wdata;
      end
      if (i_rd_we && i_rd == i_rt) begin
         o_rt_data = i_wdata;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/lc4_alu.sv ====
// Execute-stage ALU for the LC4 integer subset that also forms load/store addresses
`timescale 1ns/10ps
`default_nettype none

module lc4_alu (
   input  wire  lc4_pkg::alu_op_e i_op,
   input  wire  lc4_pkg::word_t   i_insn,
   input  wire  lc4_pkg::word_t   i_rs_data,
   input  wire  lc4_pkg::word_t   i_rt_data,
   output lc4_pkg::word_t         o_result
);

   lc4_pkg::word_t imm5;
   lc4_pkg::word_t imm6;
   lc4_pkg::word_t imm9;
   lc4_pkg::word_t opnd_b;
   lc4_pkg::word_t prod;

   // Sign-extended immediate fields
   assign imm5 = {{11{i_insn[4]}}, i_insn[4:0]};
   assign imm6 = {{10{i_insn[5]}}, i_insn[5:0]};
   assign imm9 = {{7{i_insn[8]}}, i_insn[8:0]};

   // Bit 5 picks imm5 over Rt for ADD and AND
   assign opnd_b = i_insn[5] ? imm5 : i_rt_data;

   // Low half of the product is all that MUL keeps
   assign prod = i_rs_data * i_rt_data;

   always_comb begin
      case (i_op)
         lc4_pkg::ALU_ADD:       o_result = i_rs_data + opnd_b;
         lc4_pkg::ALU_MUL:       o_result = prod;
         lc4_pkg::ALU_SUB:       o_result = i_rs_data - i_rt_data;
         lc4_pkg::ALU_AND:       o_result = i_rs_data & opnd_b;
         lc4_pkg::ALU_NOT:       o_result = ~i_rs_data;
         lc4_pkg::ALU_OR:        o_result = i_rs_data | i_rt_data;
         lc4_pkg::ALU_XOR:       o_result = i_rs_data ^ i_rt_data;
         lc4_pkg::ALU_PASS_IMM9: o_result = imm9;
         // imm8 goes above the kept low byte
         lc4_pkg::ALU_HICONST:   o_result = {i_insn[7:0], i_rs_data[7:0]};
         lc4_pkg::ALU_ADDR6:     o_result = i_rs_data + imm6;
         default:                o_result = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== verilog/lc4_hazard.sv ====
// Hazard unit, picks MX/WX bypass sources for execute and requests the load-to-use stall
`timescale 1ns/10ps
`default_nettype none

module lc4_hazard (
   input  wire  lc4_pkg::ctrl_t i_ctrl_d,
   input  wire  lc4_pkg::ctrl_t i_ctrl_x,
   input  wire  lc4_pkg::ctrl_t i_ctrl_m,
   input  wire  lc4_pkg::ctrl_t i_ctrl_w,
   output logic [1:0]           o_rs_sel,
   output logic [1:0]           o_rt_sel,
   output logic                 o_stall
);

   logic rs_hit;
   logic rt_hit;

   // Youngest writer wins, memory before writeback
   function automatic logic [1:0] byp_sel(input lc4_pkg::reg_idx_t src,
                                          input logic              re,
                                          input lc4_pkg::ctrl_t    m,
                                          input lc4_pkg::ctrl_t    w);
      // Loaded data is not ready in memory, stall covers that case
      if (re && m.regfile_we && !m.is_load && m.wsel == src) begin
         return lc4_pkg::BYP_MX;
      end
      if (re && w.regfile_we && w.wsel == src) begin
         return lc4_pkg::BYP_WX;
      end
      return lc4_pkg::BYP_REG;
   endfunction

   assign o_rs_sel = byp_sel(i_ctrl_x.r1sel, i_ctrl_x.r1re, i_ctrl_m, i_ctrl_w);
   assign o_rt_sel = byp_sel(i_ctrl_x.r2sel, i_ctrl_x.r2re, i_ctrl_m, i_ctrl_w);

   // Decode reads what the load in execute will write
   assign rs_hit = i_ctrl_d.r1re && i_ctrl_d.r1sel == i_ctrl_x.wsel;
   // Store data is patched from writeback once the store reaches memory
   assign rt_hit = i_ctrl_d.r2re && !i_ctrl_d.is_store && i_ctrl_d.r2sel == i_ctrl_x.wsel;

   assign o_stall = i_ctrl_x.is_load && i_ctrl_x.regfile_we && (rs_hit || rt_hit);

endmodule

`default_nettype wire

// ==== verilog/lc4_pipeline.sv ====
// Five-stage LC4 pipeline top, fetch through writeback with bypassing and the trace port
`timescale 1ns/10ps
`default_nettype none

module lc4_pipeline #(
   parameter lc4_pkg::word_t RESET_PC = lc4_pkg::RESET_PC
) (
   input  wire                  gwe,
   input  wire                  i_rst_n,
   output lc4_pkg::word_t       o_cur_pc,
   input  wire  lc4_pkg::word_t i_cur_insn,
   output lc4_pkg::word_t       o_dmem_addr,
   output logic                 o_dmem_we,
   output lc4_pkg::word_t       o_dmem_towrite,
   input  wire  lc4_pkg::word_t i_cur_dmem_data,
   output lc4_pkg::trace_t      o_trace
);

   // Reset contents of every stage register
   localparam lc4_pkg::stage_t FLUSH_STAGE =
      '{pc: '0, insn: '0, stall: lc4_pkg::STALL_FLUSH, ctrl: '0};

   lc4_pkg::word_t  pc_q;
   lc4_pkg::stage_t d_q, x_q, m_q, w_q;
   lc4_pkg::stage_t x_d;
   lc4_pkg::ctrl_t  ctrl_d;
   lc4_pkg::word_t  rs_data_d, rt_data_d;
   lc4_pkg::word_t  x_rs_q, x_rt_q, rs_x, rt_x, alu_x;
   lc4_pkg::word_t  m_alu_q, m_rt_q, store_data_m;
   lc4_pkg::word_t  w_alu_q, w_mem_q, w_addr_q, w_wdata;
   lc4_pkg::nzp_t   w_nzp;
   logic [1:0]      rs_sel, rt_sel;
   logic            hz_stall;

   // Fetch, next PC is always PC+1
   assign o_cur_pc = pc_q;

   // Decode
   lc4_decoder u_decoder (.i_insn(d_q.insn), .o_ctrl(ctrl_d));

   lc4_regfile u_regfile (
      .gwe(gwe), .i_rst_n(i_rst_n),
      .i_rs(ctrl_d.r1sel), .i_rt(ctrl_d.r2sel),
      .i_rd(w_q.ctrl.wsel), .i_wdata(w_wdata), .i_rd_we(w_q.ctrl.regfile_we),
      .o_rs_data(rs_data_d), .o_rt_data(rt_data_d)
   );

   lc4_hazard u_hazard (
      .i_ctrl_d(ctrl_d), .i_ctrl_x(x_q.ctrl), .i_ctrl_m(m_q.ctrl), .i_ctrl_w(w_q.ctrl),
      .o_rs_sel(rs_sel), .o_rt_sel(rt_sel), .o_stall(hz_stall)
   );

   // Decoded instruction, or a load-use bubble in its place
   always_comb begin
      x_d = '{pc: d_q.pc, insn: d_q.insn, stall: d_q.stall, ctrl: ctrl_d};
      if (hz_stall) begin
         x_d.stall = lc4_pkg::STALL_LOAD_USE;
         x_d.ctrl  = '0;
      end
   end

   // Control state, PC and D hold during a stall
   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc_q <= RESET_PC;
         d_q  <= FLUSH_STAGE;
         x_q  <= FLUSH_STAGE;
         m_q  <= FLUSH_STAGE;
         w_q  <= FLUSH_STAGE;
      end else begin
         if (!hz_stall) begin
            pc_q <= pc_q + 16'd1;
            d_q  <= '{pc: pc_q, insn: i_cur_insn, stall: lc4_pkg::STALL_NONE, ctrl: '0};
         end
         x_q <= x_d;
         m_q <= x_q;
         w_q <= m_q;
      end
   end

   // Execute operands, MX from the memory ALU word, WX from the writeback value
   assign rs_x = (rs_sel == lc4_pkg::BYP_MX) ? m_alu_q :
                 (rs_sel == lc4_pkg::BYP_WX) ? w_wdata : x_rs_q;
   assign rt_x = (rt_sel == lc4_pkg::BYP_MX) ? m_alu_q :
                 (rt_sel == lc4_pkg::BYP_WX) ? w_wdata : x_rt_q;

   lc4_alu u_alu (
      .i_op(x_q.ctrl.alu_op), .i_insn(x_q.insn),
      .i_rs_data(rs_x), .i_rt_data(rt_x), .o_result(alu_x)
   );

   // Memory, store data picks up a load that just reached writeback
   assign store_data_m = (w_q.ctrl.regfile_we && m_q.ctrl.r2re &&
                          w_q.ctrl.wsel == m_q.ctrl.r2sel) ? w_wdata : m_rt_q;
   assign o_dmem_we      = m_q.ctrl.is_store;
   assign o_dmem_addr    = (m_q.ctrl.is_load || m_q.ctrl.is_store) ? m_alu_q : '0;
   assign o_dmem_towrite = m_q.ctrl.is_store ? store_data_m : '0;

   // Operand and result words, no reset
   always_ff @(posedge gwe) begin
      x_rs_q   <= rs_data_d;
      x_rt_q   <= rt_data_d;
      m_alu_q  <= alu_x;
      m_rt_q   <= rt_x;
      w_alu_q  <= m_alu_q;
      w_addr_q <= o_dmem_addr;
      // Loaded word for loads, written word for stores
      w_mem_q  <= m_q.ctrl.is_load ? i_cur_dmem_data : o_dmem_towrite;
   end

   // Writeback value and its condition codes
   assign w_wdata = w_q.ctrl.is_load ? w_mem_q : w_alu_q;
   assign w_nzp   = w_wdata[15] ? 3'b100 : (w_wdata == '0) ? 3'b010 : 3'b001;

   assign o_trace = '{stall: w_q.stall, pc: w_q.pc, insn: w_q.insn,
                      regfile_we: w_q.ctrl.regfile_we, wsel: w_q.ctrl.wsel, wdata: w_wdata,
                      nzp_we: w_q.ctrl.nzp_we, nzp_bits: w_nzp,
                      dmem_we: w_q.ctrl.is_store, dmem_addr: w_addr_q, dmem_data: w_mem_q};

   // Bubbles never reach the data memory write port
   a_store_real: assert property (@(posedge gwe) disable iff (!i_rst_n)
      o_dmem_we |-> m_q.stall == lc4_pkg::STALL_NONE);

   // Hazard unit never stalls behind a bubble already sitting in execute
   a_stall_live: assert property (@(posedge gwe) disable iff (!i_rst_n)
      hz_stall |-> x_q.stall == lc4_pkg::STALL_NONE);

endmodule

`default_nettype wire

// ==== test/lc4_model.svh ====
// In-order LC4 model, included inside tb_lc4 to predict each committed trace entry
`ifndef LC4_MODEL_SVH
`define LC4_MODEL_SVH

// Architectural state, advanced one instruction at a time
lc4_pkg::word_t model_regs [8];
lc4_pkg::word_t model_dmem [256];
lc4_pkg::nzp_t  model_nzp;

// True when insn needs register r in execute; a store's data register is left out
function automatic logic reads_reg(input lc4_pkg::word_t insn, input lc4_pkg::reg_idx_t r);
   logic uses_rt;
   // Register forms only, and NOT has no second source
   uses_rt = !insn[5] && !(insn[15:12] == 4'h5 && insn[4:3] == 2'b01);
   case (insn[15:12])
      4'h1, 4'h5: return insn[8:6] == r || (uses_rt && insn[2:0] == r);
      4'h6, 4'h7: return insn[8:6] == r;
      4'hd:       return insn[11:9] == r;
      default:    return 1'b0;
   endcase
endfunction

// Execute one instruction and fill in the trace it should leave
task automatic model_step(input lc4_pkg::word_t pc, input lc4_pkg::word_t insn,
                          output lc4_pkg::trace_t t);
   lc4_pkg::word_t rs;
   lc4_pkg::word_t rt;
   lc4_pkg::word_t imm5;
   lc4_pkg::word_t val;
   rs     = model_regs[insn[8:6]];
   rt     = model_regs[insn[2:0]];
   imm5   = {{11{insn[4]}}, insn[4:0]};
   val    = '0;
   t      = '0;
   t.pc   = pc;
   t.insn = insn;
   case (insn[15:12])
      4'h1: begin
         case (insn[5:3])
            3'b000:  val = rs + rt;
            3'b001:  val = rs * rt;
            3'b010:  val = rs - rt;
            default: val = rs + imm5;
         endcase
      end
      4'h5: begin
         case (insn[5:3])
            3'b000:  val = rs & rt;
            3'b001:  val = ~rs;
            3'b010:  val = rs | rt;
            3'b011:  val = rs ^ rt;
            default: val = rs & imm5;
         endcase
      end
      4'h6, 4'h7: begin
         t.dmem_addr = rs + {{10{insn[5]}}, insn[5:0]};
         t.dmem_we   = insn[12];
         if (t.dmem_we) begin
            // Store data comes from the Rd field
            t.dmem_data = model_regs[insn[11:9]];
            model_dmem[t.dmem_addr[7:0]] = t.dmem_data;
         end else begin
            t.dmem_data = model_dmem[t.dmem_addr[7:0]];
            val = t.dmem_data;
         end
      end
      4'h9: val = {{7{insn[8]}}, insn[8:0]};
      // Upper byte replaced, low byte of Rd kept
      4'hd: val = {insn[7:0], model_regs[insn[11:9]][7:0]};
      default: val = '0;
   endcase
   // Every kept opcode except STR and NOP writes Rd and the condition codes
   if (insn[15:12] inside {4'h1, 4'h5, 4'h6, 4'h9, 4'hd}) begin
      model_regs[insn[11:9]] = val;
      model_nzp    = val[15] ? 3'b100 : (val == 16'd0) ? 3'b010 : 3'b001;
      t.regfile_we = 1'b1;
      t.wsel       = insn[11:9];
      t.wdata      = val;
      t.nzp_we     = 1'b1;
      t.nzp_bits   = model_nzp;
   end
endtask

`endif

// ==== test/tb_lc4.sv ====
// Testbench for the LC4 pipeline that checks a random program against an in-order model
`timescale 1ns/10ps
`default_nettype none

module tb_lc4;

   localparam lc4_pkg::word_t BOOT_PC = 16'h8200;
   localparam int CLK_PERIOD  = 40;
   localparam int DRIVE_DELAY = 2;
   localparam int NUM_COMMITS = 256;
   // Allows two cycles for each of 300 instructions
   localparam int WATCHDOG_NS = 300 * 2 * CLK_PERIOD;

   logic            gwe = 1'b0;
   logic            i_rst_n;
   lc4_pkg::word_t  cur_pc;
   lc4_pkg::word_t  cur_insn;
   lc4_pkg::word_t  dmem_addr;
   lc4_pkg::word_t  dmem_towrite;
   lc4_pkg::word_t  dmem_rdata;
   logic            dmem_we;
   lc4_pkg::trace_t trace;

   lc4_pkg::word_t imem [256];
   lc4_pkg::word_t dmem [256];
   int             errors     = 0;
   int             committed  = 0;
   int             cycle      = 0;
   logic           bubble_due = 1'b0;
   lc4_pkg::word_t exp_pc     = BOOT_PC;
   logic [31:0]    rng        = 32'hb769_a70c;

   `include "lc4_model.svh"

   always #(CLK_PERIOD / 2) gwe = ~gwe;

   lc4_pipeline #(.RESET_PC(BOOT_PC)) uut (
      .gwe(gwe), .i_rst_n(i_rst_n), .o_cur_pc(cur_pc), .i_cur_insn(cur_insn),
      .o_dmem_addr(dmem_addr), .o_dmem_we(dmem_we), .o_dmem_towrite(dmem_towrite),
      .i_cur_dmem_data(dmem_rdata), .o_trace(trace)
   );

   // Both memories answer in the same cycle from the low address byte
   assign cur_insn   = imem[cur_pc[7:0]];
   assign dmem_rdata = dmem[dmem_addr[7:0]];

   always @(posedge gwe) begin
      if (dmem_we) begin
         dmem[dmem_addr[7:0]] <= dmem_towrite;
      end
   end

   function automatic logic [31:0] rand_step(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Every address bit shows up in the word
   function automatic lc4_pkg::word_t fill_word(input logic [7:0] a);
      return {a, ~a} ^ 16'h3c5a;
   endfunction

   // One kept instruction with registers limited to R0-R1 in dense mode
   function automatic lc4_pkg::word_t make_insn(input logic [31:0] r, input logic dense);
      logic [2:0] d;
      logic [2:0] s;
      logic [2:0] t;
      d = dense ? {2'b00, r[4]} : r[6:4];
      s = dense ? {2'b00, r[7]} : r[9:7];
      t = dense ? {2'b00, r[10]} : r[12:10];
      case (r[3:0])
         4'd0:         return {4'h1, d, s, 3'b000, t};
         4'd1:         return {4'h1, d, s, 3'b001, t};
         4'd2:         return {4'h1, d, s, 3'b010, t};
         4'd3:         return {4'h1, d, s, 1'b1, r[20:16]};
         4'd4:         return {4'h5, d, s, 3'b000, t};
         4'd5:         return {4'h5, d, s, 3'b001, t};
         4'd6:         return {4'h5, d, s, 3'b010, t};
         4'd7:         return {4'h5, d, s, 3'b011, t};
         4'd8:         return {4'h5, d, s, 1'b1, r[20:16]};
         4'd9:         return {4'h9, d, r[24:16]};
         4'd10:        return {4'hd, d, 1'b1, r[23:16]};
         4'd11, 4'd12: return {4'h6, d, s, r[21:16]};
         4'd13, 4'd14: return {4'h7, d, s, r[21:16]};
         default:      return {4'h0, r[27:16]};
      endcase
   endfunction

   task automatic check_field(input string what, input lc4_pkg::word_t got,
                              input lc4_pkg::word_t want);
      assert (got == want) else begin
         errors++;
         $display("MISMATCH at %0t ns: %s near pc %h, got %h expected %h",
                  $time, what, exp_pc, got, want);
      end
   endtask

   // Judge one writeback cycle
   task automatic check_cycle();
      lc4_pkg::trace_t want;
      lc4_pkg::word_t  insn;
      if (cycle < 4) begin
         check_field("fill stall", 16'(trace.stall), 16'(lc4_pkg::STALL_FLUSH));
         // First instruction reaches memory in the fourth cycle
         if (cycle < 3) begin
            check_field("fill dmem_we", 16'(dmem_we), 16'd0);
         end
      end else if (trace.stall == lc4_pkg::STALL_LOAD_USE) begin
         check_field("load-use bubble", 16'd1, 16'(bubble_due));
         bubble_due = 1'b0;
      end else begin
         check_field("stall code", 16'(trace.stall), 16'(lc4_pkg::STALL_NONE));
         check_field("load-use bubble", 16'd0, 16'(bubble_due));
         insn = imem[exp_pc[7:0]];
         model_step(exp_pc, insn, want);
         check_field("pc", trace.pc, want.pc);
         check_field("insn", trace.insn, want.insn);
         check_field("regfile_we", 16'(trace.regfile_we), 16'(want.regfile_we));
         if (want.regfile_we) begin
            check_field("wsel", 16'(trace.wsel), 16'(want.wsel));
            check_field("wdata", trace.wdata, want.wdata);
         end
         check_field("nzp_we", 16'(trace.nzp_we), 16'(want.nzp_we));
         if (want.nzp_we) begin
            check_field("nzp_bits", 16'(trace.nzp_bits), 16'(want.nzp_bits));
         end
         check_field("dmem_we", 16'(trace.dmem_we), 16'(want.dmem_we));
         check_field("dmem_addr", trace.dmem_addr, want.dmem_addr);
         check_field("dmem_data", trace.dmem_data, want.dmem_data);
         // A load stalls its successor only when that word reads the loaded register
         bubble_due = insn[15:12] == 4'h6 &&
                      reads_reg(imem[exp_pc[7:0] + 8'd1], insn[11:9]);
         exp_pc = exp_pc + 16'd1;
         committed++;
      end
      cycle++;
   endtask

   task automatic finish_run();
      $display("Checked %0d instructions in %0d cycles, %0d errors", committed, cycle, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   endtask

   initial begin
      i_rst_n = 1'b0;
      // Random first half and R0-R1 only in the second half
      for (int i = 0; i < 256; i++) begin
         rng           = rand_step(rng);
         imem[i]       = make_insn(rng, i >= 128);
         dmem[i]      <= fill_word(i[7:0]);
         model_dmem[i] = fill_word(i[7:0]);
      end
      for (int i = 0; i < 8; i++) begin
         model_regs[i] = '0;
      end
      model_nzp = '0;
      repeat (3) @(posedge gwe);
      #(DRIVE_DELAY) i_rst_n = 1'b1;
      while (committed < NUM_COMMITS) begin
         @(negedge gwe);
         check_cycle();
      end
      finish_run();
   end

   // Watchdog
   initial begin
      #(WATCHDOG_NS);
      errors++;
      $display("Timeout: only %0d of %0d instructions committed before the watchdog expired",
               committed, NUM_COMMITS);
      finish_run();
   end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/lc4_pkg.sv
verilog/lc4_decoder.sv
verilog/lc4_regfile.sv
verilog/lc4_alu.sv
verilog/lc4_hazard.sv
verilog/lc4_pipeline.sv
+incdir+test
test/tb_lc4.sv

// ==== Makefile ====
OBJ_DIR := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -f sources.f --top-module tb_lc4 --Mdir $(OBJ_DIR) -o tb_lc4

run: compile
	@out="$$(./$(OBJ_DIR)/tb_lc4)"; echo "$$out"; echo "$$out" | grep -qx 'PASS: all tests'

clean:
	rm -rf $(OBJ_DIR)
